// ==== Makefile ====
TOP := barrelShifterTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# the run log decides pass or fail, not the exit code of the simulator.
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/barrelShifter.sv ====
`timescale 1ns/1ns

module barrelShifter #(
    parameter int DataWidth = shiftDataPkg::DataWidth
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     inValid,
    output logic                     inReady,
    input  shiftDataPkg::dataWord_t    inData,
    input  shiftDataPkg::shiftAmount_t inAmount,
    input  shiftOpPkg::shiftDir_t      inDir,

    output logic                     outValid,
    input  logic                     outReady,
    output shiftDataPkg::dataWord_t    outData
);
    import shiftDataPkg::*;
    import shiftOpPkg::*;

    // link[i] feeds stage i, link[NumStages] is the output side.
    shiftStageIf link [NumStages+1] ();

    // input ports drive the first link.
    assign link[0].valid  = inValid;
    assign link[0].data   = inData;
    assign link[0].amount = inAmount;
    assign link[0].dir    = inDir;
    assign inReady        = link[0].ready; // low only when every slot is full.

    // stage 0 shifts by 1, stage 4 by 16.
    for (genvar g = 0; g < NumStages; g++) begin : gStage
        shiftStage #(
            .DataWidth  (DataWidth),
            .StageIndex (g)
        ) u_shiftStage (
            .clk  (clk),
            .rst  (rst),
            .up   (link[g]),
            .down (link[g+1])
        );
    end

    // last link goes to the output ports; its amount and dir are spent.
    assign outValid              = link[NumStages].valid;
    assign outData               = link[NumStages].data;
    assign link[NumStages].ready = outReady;

endmodule

// ==== design/shiftDataPkg.sv ====
package shiftDataPkg;

    // width of the word that travels through the shifter.
    localparam int DataWidth = 32;

    // one amount bit per layer, so log2 of the word width.
    localparam int AmountWidth = $clog2(DataWidth);

    // the data word and the shift amount.
    typedef logic [DataWidth-1:0] dataWord_t;
    typedef logic [AmountWidth-1:0] shiftAmount_t;

endpackage

// ==== design/shiftOpPkg.sv ====
package shiftOpPkg;

    // direction that travels with every operation.
    typedef enum logic {
        ShiftLeft       = 1'b0, // logical, zero fill.
        ShiftRightArith = 1'b1  // arithmetic, sign fill.
    } shiftDir_t;

    // one layer per amount bit.
    localparam int NumStages = shiftDataPkg::AmountWidth;

endpackage

// ==== design/shiftStage.sv ====
`timescale 1ns/1ns

module shiftStage #(
    parameter int DataWidth  = shiftDataPkg::DataWidth,
    parameter int StageIndex = 0
) (
    input logic     clk,
    input logic     rst,
    shiftStageIf.dst up,
    shiftStageIf.src down
);
    import shiftDataPkg::*;
    import shiftOpPkg::*;

    // this layer moves the word by 2**StageIndex bits.
    localparam int Distance = 1 << StageIndex;

    logic         shiftEn;
    logic         signFill;
    dataWord_t    leftResult;
    dataWord_t    rightResult;
    dataWord_t    shifted;
    logic         loadEn;

    logic         validQ;
    dataWord_t    dataQ;
    shiftAmount_t amountQ;
    shiftDir_t    dirQ;

    // amount bit for this layer.
    assign shiftEn  = up.amount[StageIndex];
    assign signFill = up.data[DataWidth-1]; // top bit of the incoming word.

    // both candidate results for the whole layer.
    assign leftResult  = up.data << Distance;
    assign rightResult = {{Distance{signFill}}, up.data[DataWidth-1:Distance]};

    always_comb begin
        if (!shiftEn) begin
            shifted = up.data;
        end else if (up.dir == ShiftLeft) begin
            shifted = leftResult;
        end else begin
            shifted = rightResult;
        end
    end

    // slot can take a new operation if it is empty or is being drained.
    assign up.ready = !validQ || down.ready;
    assign loadEn   = up.valid && up.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (loadEn) begin
            validQ <= 1'b1;
        end else if (down.ready) begin
            validQ <= 1'b0; // result went downstream.
        end
    end

    // payload only changes on a load, so it holds under back-pressure.
    always_ff @(posedge clk) begin
        if (loadEn) begin
            dataQ   <= shifted;
            amountQ <= up.amount; // later layers still need their bits.
            dirQ    <= up.dir;
        end
    end

    assign down.valid  = validQ;
    assign down.data   = dataQ;
    assign down.amount = amountQ;
    assign down.dir    = dirQ;

endmodule

// ==== design/shiftStageIf.sv ====
`timescale 1ns/1ns

interface shiftStageIf;
    import shiftDataPkg::*;
    import shiftOpPkg::*;

    logic         valid;  // sender has an operation.
    logic         ready;  // receiver can take it.
    dataWord_t    data;   // partially shifted word.
    shiftAmount_t amount;
    shiftDir_t    dir;

    // payload is held steady while valid waits on ready.
    modport src (
        output valid,
        output data,
        output amount,
        output dir,
        input  ready
    );

    modport dst (
        input  valid,
        input  data,
        input  amount,
        input  dir,
        output ready
    );

endinterface

// ==== dv/barrelShifterTb.sv ====
`timescale 1ns/1ns

module barrelShifterTb;
    import shiftDataPkg::*;
    import shiftOpPkg::*;

    localparam int NumDirected   = 12;
    localparam int NumRows       = 24;
    localparam int TimeoutCycles = 1000;
    localparam int ProbeRow      = 5; // arithmetic right shift of a negative word by 1.

    typedef struct packed {
        dataWord_t    data;
        shiftAmount_t amount;
        shiftDir_t    dir;
        dataWord_t    expected;
    } tableRow_t;

    logic         clk;
    logic         rst;
    logic         inValid;
    logic         inReady;
    dataWord_t    inData;
    shiftAmount_t inAmount;
    shiftDir_t    inDir;
    logic         outValid;
    logic         outReady;
    dataWord_t    outData;

    tableRow_t    rows [NumRows];
    integer       seed;

    barrelShifter #(
        .DataWidth (DataWidth)
    ) u_barrelShifter (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .inAmount (inAmount),
        .inDir    (inDir),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    always #5 clk = ~clk;

    // left fills zeros from below, arithmetic right copies bit 31 from above.
    function automatic dataWord_t shiftByRule(dataWord_t value, shiftAmount_t amount,
                                              shiftDir_t dir);
        if (dir == ShiftLeft) begin
            return value << amount;
        end
        return dataWord_t'($signed(value) >>> amount);
    endfunction

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic timeoutFail(string what);
        $display("timeout: gave up waiting for %s after %0d cycles", what, TimeoutCycles);
        abortRun();
    endtask

    task automatic checkWord(string what, dataWord_t actual, dataWord_t expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkBit(string what, logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkCount(string what, int actual, int expected);
        if (actual != expected) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic setRow(int idx, dataWord_t data, shiftAmount_t amount, shiftDir_t dir,
                          dataWord_t expected);
        rows[idx].data     = data;
        rows[idx].amount   = amount;
        rows[idx].dir      = dir;
        rows[idx].expected = expected;
    endtask

    task automatic loadTable();
        logic [31:0] rnd;
        dataWord_t   word;
        shiftDir_t   dir;
        setRow(0,  32'h8000_0001, 5'd0,  ShiftLeft,       32'h8000_0001);
        setRow(1,  32'hC000_0003, 5'd1,  ShiftLeft,       32'h8000_0006);
        setRow(2,  32'h1234_5678, 5'd16, ShiftLeft,       32'h5678_0000);
        setRow(3,  32'h0000_0003, 5'd31, ShiftLeft,       32'h8000_0000);
        setRow(4,  32'h8765_4321, 5'd0,  ShiftRightArith, 32'h8765_4321);
        setRow(5,  32'h8765_4321, 5'd1,  ShiftRightArith, 32'hC3B2_A190);
        setRow(6,  32'h8765_4321, 5'd15, ShiftRightArith, 32'hFFFF_0ECA);
        setRow(7,  32'h8765_4321, 5'd31, ShiftRightArith, 32'hFFFF_FFFF);
        setRow(8,  32'h7654_3210, 5'd0,  ShiftRightArith, 32'h7654_3210);
        setRow(9,  32'h7654_3210, 5'd1,  ShiftRightArith, 32'h3B2A_1908);
        setRow(10, 32'h7654_3210, 5'd15, ShiftRightArith, 32'h0000_ECA8);
        setRow(11, 32'h7654_3210, 5'd31, ShiftRightArith, 32'h0000_0000);
        for (int i = NumDirected; i < NumRows; i++) begin
            word = $random(seed);
            rnd  = $random(seed);
            dir  = rnd[8] ? ShiftRightArith : ShiftLeft;
            setRow(i, word, rnd[AmountWidth-1:0], dir,
                   shiftByRule(word, rnd[AmountWidth-1:0], dir));
        end
    endtask

    // past the end of the table the input goes idle.
    task automatic driveInputs(int idx);
        if (idx < NumRows) begin
            inValid  = 1'b1;
            inData   = rows[idx].data;
            inAmount = rows[idx].amount;
            inDir    = rows[idx].dir;
        end else begin
            inValid  = 1'b0;
        end
    endtask

    // latency counted from the input handshake edge to the output handshake edge.
    task automatic checkLatency();
        int waitCycles;
        int edges;
        @(posedge clk);
        #1;
        outReady = 1'b1;
        driveInputs(ProbeRow);
        waitCycles = 0;
        @(negedge clk);
        while (!inReady) begin
            waitCycles++;
            if (waitCycles > TimeoutCycles) timeoutFail("inReady for the latency probe");
            @(negedge clk);
        end
        @(posedge clk); // input handshake edge.
        #1;
        inValid = 1'b0;
        edges = 0;
        @(negedge clk);
        while (!outValid) begin
            edges++;
            if (edges > TimeoutCycles) timeoutFail("outValid of the latency probe");
            @(negedge clk);
        end
        checkCount("latency in cycles", edges + 1, NumStages);
        checkWord("latency probe outData", outData, rows[ProbeRow].expected);
        @(posedge clk);
        #1;
    endtask

    // flags are sampled at the falling edge, where they hold what the next rising edge sees.
    task automatic runTable(bit useStalls);
        dataWord_t   expectQ [$];
        dataWord_t   want;
        logic [31:0] rnd;
        int          sent;
        int          received;
        int          inFlight;
        int          cycles;
        bit          sawFull;
        sent     = 0;
        received = 0;
        inFlight = 0;
        cycles   = 0;
        sawFull  = 1'b0;
        @(posedge clk);
        #1;
        outReady = 1'b1;
        driveInputs(sent);
        while (received < NumRows) begin
            @(negedge clk);
            checkBit("inReady", inReady, !(inFlight == NumStages && !outReady));
            if (!inReady) sawFull = 1'b1;
            if (outValid && outReady) begin
                if (expectQ.size() == 0) begin
                    $display("a result left the shifter with no operation outstanding");
                    abortRun();
                end
                want = expectQ.pop_front();
                checkWord("outData", outData, want);
                received++;
                inFlight--;
            end
            if (inValid && inReady) begin
                expectQ.push_back(rows[sent].expected);
                sent++;
                inFlight++;
            end
            cycles++;
            if (cycles > TimeoutCycles) timeoutFail("all table results");
            @(posedge clk);
            #1;
            driveInputs(sent);
            if (useStalls) begin
                rnd      = $random(seed);
                outReady = (rnd[1:0] == 2'b00); // mostly stalled, so the slots fill.
            end
        end
        outReady = 1'b1;
        if (useStalls && !sawFull) begin
            $display("inReady never dropped, so the full pipeline was not reached");
            abortRun();
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        inValid  = 1'b1; // offered through reset, which must still leave every slot empty.
        inData   = '0;
        inAmount = '0;
        inDir    = ShiftLeft;
        outReady = 1'b0;
        seed     = 32'h76d0_5a1c;
        loadTable();

        repeat (16) @(posedge clk);
        #1;
        rst     = 1'b0;
        inValid = 1'b0;
        @(negedge clk);
        checkBit("outValid after reset", outValid, 1'b0);
        checkBit("inReady after reset", inReady, 1'b1);

        checkLatency();
        runTable(1'b0); // streaming without stalls.
        runTable(1'b1);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== dv/barrelShifter_assertions.sv ====
`timescale 1ns/1ns

module barrelShifter_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    inReady,
    input logic                    outValid,
    input logic                    outReady,
    input shiftDataPkg::dataWord_t outData
);
    import shiftDataPkg::*;

    // a stalled result must not change under the consumer.
    property outHeldWhileStalled;
        @(posedge clk) disable iff (rst)
            outValid && !outReady |=> $stable(outData);
    endproperty

    property outEmptyAfterReset;
        @(posedge clk) rst |=> !outValid;
    endproperty

    // a draining output means no slot can block the input.
    property inReadyWhenDraining;
        @(posedge clk) disable iff (rst)
            outReady |-> inReady;
    endproperty

    assert property (outHeldWhileStalled)
        else $error("outData changed while outValid waited on outReady");
    assert property (outEmptyAfterReset)
        else $error("outValid high in the cycle after reset");
    assert property (inReadyWhenDraining)
        else $error("inReady low while outReady was high");

endmodule

bind barrelShifter barrelShifter_assertions u_barrelShifterAssertions (
    .clk      (clk),
    .rst      (rst),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
);

// ==== filelist.f ====
design/shiftDataPkg.sv
design/shiftOpPkg.sv
design/shiftStageIf.sv
design/shiftStage.sv
design/barrelShifter.sv
dv/barrelShifter_assertions.sv
dv/barrelShifterTb.sv
